// ==== logic/lrsc_adapter.sv ====
// ==========================================================
// Exclusive-access adapter top, placed between an upstream master
// and a memory without exclusive support
// ==========================================================
`timescale 1ns/100ps

module lrsc_adapter
    import lrsc_pkg::*;
#(
    parameter logic [ADDR_W-1:0] ADDR_BEGIN = 16'h1000,
    parameter logic [ADDR_W-1:0] ADDR_END   = 16'h10FF
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    // Upstream side
    input  logic    up_ar_valid_i,
    input  ar_req_t up_ar_i,
    output logic    up_ar_ready_o,
    output logic    up_r_valid_o,
    output r_rsp_t  up_r_o,
    input  logic    up_r_ready_i,
    input  logic    up_aw_valid_i,
    input  aw_req_t up_aw_i,
    output logic    up_aw_ready_o,
    input  logic    up_w_valid_i,
    input  w_req_t  up_w_i,
    output logic    up_w_ready_o,
    output logic    up_b_valid_o,
    output b_rsp_t  up_b_o,
    input  logic    up_b_ready_i,
    // Downstream memory side
    output logic    dn_ar_valid_o,
    output ar_req_t dn_ar_o,
    input  logic    dn_ar_ready_i,
    input  logic    dn_r_valid_i,
    input  r_rsp_t  dn_r_i,
    output logic    dn_r_ready_o,
    output logic    dn_aw_valid_o,
    output aw_req_t dn_aw_o,
    input  logic    dn_aw_ready_i,
    output logic    dn_w_valid_o,
    output w_req_t  dn_w_o,
    input  logic    dn_w_ready_i,
    input  logic    dn_b_valid_i,
    input  b_rsp_t  dn_b_i,
    output logic    dn_b_ready_o
);

    resv_set_t          resv_set;
    resv_clr_t          resv_clr;
    logic [ADDR_W-1:0]  check_addr;
    logic [N_SLOTS-1:0] hit;

    lrsc_read_ctrl #(
        .ADDR_BEGIN (ADDR_BEGIN),
        .ADDR_END   (ADDR_END)
    ) u_read_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .up_ar_valid_i (up_ar_valid_i),
        .up_ar_i       (up_ar_i),
        .up_ar_ready_o (up_ar_ready_o),
        .dn_ar_valid_o (dn_ar_valid_o),
        .dn_ar_o       (dn_ar_o),
        .dn_ar_ready_i (dn_ar_ready_i),
        .dn_r_valid_i  (dn_r_valid_i),
        .dn_r_i        (dn_r_i),
        .dn_r_ready_o  (dn_r_ready_o),
        .up_r_valid_o  (up_r_valid_o),
        .up_r_o        (up_r_o),
        .up_r_ready_i  (up_r_ready_i),
        .resv_set_o    (resv_set)
    );

    lrsc_write_ctrl #(
        .ADDR_BEGIN (ADDR_BEGIN),
        .ADDR_END   (ADDR_END)
    ) u_write_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .up_aw_valid_i (up_aw_valid_i),
        .up_aw_i       (up_aw_i),
        .up_aw_ready_o (up_aw_ready_o),
        .dn_aw_valid_o (dn_aw_valid_o),
        .dn_aw_o       (dn_aw_o),
        .dn_aw_ready_i (dn_aw_ready_i),
        .up_w_valid_i  (up_w_valid_i),
        .up_w_i        (up_w_i),
        .up_w_ready_o  (up_w_ready_o),
        .dn_w_valid_o  (dn_w_valid_o),
        .dn_w_o        (dn_w_o),
        .dn_w_ready_i  (dn_w_ready_i),
        .dn_b_valid_i  (dn_b_valid_i),
        .dn_b_i        (dn_b_i),
        .dn_b_ready_o  (dn_b_ready_o),
        .up_b_valid_o  (up_b_valid_o),
        .up_b_o        (up_b_o),
        .up_b_ready_i  (up_b_ready_i),
        .check_addr_o  (check_addr),
        .hit_i         (hit),
        .resv_clr_o    (resv_clr)
    );

    // Reservation table, one slot per ID
    for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
        lrsc_resv_slot #(
            .SLOT_ID (ID_W'(i))
        ) u_slot (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .set_i        (resv_set),
            .clr_i        (resv_clr),
            .check_addr_i (check_addr),
            .hit_o        (hit[i])
        );
    end

endmodule

// ==== logic/lrsc_pkg.sv ====
// ==========================================================
// Widths, channel payloads and reservation requests shared by
// the exclusive-access adapter RTL and its testbench
// ==========================================================

package lrsc_pkg;

    // Bus geometry
    localparam int unsigned ADDR_W  = 16;
    localparam int unsigned DATA_W  = 32;
    localparam int unsigned ID_W    = 2;
    localparam int unsigned STRB_W  = DATA_W / 8;

    // One reservation slot per transaction ID
    localparam int unsigned N_SLOTS = 2 ** ID_W;

    // Response codes, upper bit flags an error
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Address channels
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic              lock;
    } ar_req_t;

    typedef ar_req_t aw_req_t;

    // Data and response channels
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
    } r_rsp_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_req_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_rsp_t;

    // Reservation table requests
    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } resv_set_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } resv_clr_t;

endpackage

// ==== logic/lrsc_read_ctrl.sv ====
// ==========================================================
// Read path, forwards AR and R, places reservations for
// exclusive reads inside the window and rewrites the R response
// ==========================================================
`timescale 1ns/100ps

module lrsc_read_ctrl
    import lrsc_pkg::*;
#(
    parameter logic [ADDR_W-1:0] ADDR_BEGIN = '0,
    parameter logic [ADDR_W-1:0] ADDR_END   = '0
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      up_ar_valid_i,
    input  ar_req_t   up_ar_i,
    output logic      up_ar_ready_o,
    output logic      dn_ar_valid_o,
    output ar_req_t   dn_ar_o,
    input  logic      dn_ar_ready_i,
    input  logic      dn_r_valid_i,
    input  r_rsp_t    dn_r_i,
    output logic      dn_r_ready_o,
    output logic      up_r_valid_o,
    output r_rsp_t    up_r_o,
    input  logic      up_r_ready_i,
    output resv_set_t resv_set_o
);

    typedef enum logic {
        R_IDLE,
        R_WAIT_R
    } r_state_e;

    r_state_e r_state_d, r_state_q;
    logic     excl_d, excl_q;
    logic     ar_excl;

    // Lock never reaches the memory
    always_comb begin
        dn_ar_o      = up_ar_i;
        dn_ar_o.lock = 1'b0;
    end

    assign ar_excl = up_ar_i.lock && (up_ar_i.addr >= ADDR_BEGIN) &&
                     (up_ar_i.addr <= ADDR_END);

    always_comb begin
        dn_ar_valid_o = 1'b0;
        up_ar_ready_o = 1'b0;
        dn_r_ready_o  = 1'b0;
        up_r_valid_o  = 1'b0;
        up_r_o        = dn_r_i;
        resv_set_o    = '{valid: 1'b0, id: up_ar_i.id, addr: up_ar_i.addr};
        excl_d        = excl_q;
        r_state_d     = r_state_q;

        case (r_state_q)
            R_IDLE: begin
                dn_ar_valid_o = up_ar_valid_i;
                up_ar_ready_o = dn_ar_ready_i;
                if (up_ar_valid_i && dn_ar_ready_i) begin
                    resv_set_o.valid = ar_excl;
                    excl_d           = ar_excl;
                    r_state_d        = R_WAIT_R;
                end
            end
            R_WAIT_R: begin
                dn_r_ready_o = up_r_ready_i;
                up_r_valid_o = dn_r_valid_i;
                // Errors pass unchanged
                if (!dn_r_i.resp[1]) begin
                    up_r_o.resp = excl_q ? RESP_EXOKAY : RESP_OKAY;
                end
                if (dn_r_valid_i && up_r_ready_i) begin
                    excl_d    = 1'b0;
                    r_state_d = R_IDLE;
                end
            end
            default: r_state_d = R_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_state_q <= R_IDLE;
            excl_q    <= 1'b0;
        end else begin
            r_state_q <= r_state_d;
            excl_q    <= excl_d;
        end
    end

endmodule

// ==== logic/lrsc_resv_slot.sv ====
// ==========================================================
// Single reservation entry for one ID, loaded by reads and
// dropped by writes to the same address
// ==========================================================
`timescale 1ns/100ps

module lrsc_resv_slot
    import lrsc_pkg::*;
#(
    parameter logic [ID_W-1:0] SLOT_ID = '0
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  resv_set_t         set_i,
    input  resv_clr_t         clr_i,
    input  logic [ADDR_W-1:0] check_addr_i,
    output logic              hit_o
);

    logic              valid_q;
    logic [ADDR_W-1:0] addr_q;

    // Set is evaluated last so it wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            if (clr_i.valid && valid_q && (clr_i.addr == addr_q)) begin
                valid_q <= 1'b0;
            end
            if (set_i.valid && (set_i.id == SLOT_ID)) begin
                valid_q <= 1'b1;
            end
        end
    end

    // Reserved address only matters while valid_q is high
    always_ff @(posedge clk_i) begin
        if (set_i.valid && (set_i.id == SLOT_ID)) begin
            addr_q <= set_i.addr;
        end
    end

    assign hit_o = valid_q && (addr_q == check_addr_i);

endmodule

// ==== logic/lrsc_write_ctrl.sv ====
// ==========================================================
// Write path, checks reservations for exclusive writes, forwards
// or swallows the write, clears reservations and forms B
// ==========================================================
`timescale 1ns/100ps

module lrsc_write_ctrl
    import lrsc_pkg::*;
#(
    parameter logic [ADDR_W-1:0] ADDR_BEGIN = '0,
    parameter logic [ADDR_W-1:0] ADDR_END   = '0
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               up_aw_valid_i,
    input  aw_req_t            up_aw_i,
    output logic               up_aw_ready_o,
    output logic               dn_aw_valid_o,
    output aw_req_t            dn_aw_o,
    input  logic               dn_aw_ready_i,
    input  logic               up_w_valid_i,
    input  w_req_t             up_w_i,
    output logic               up_w_ready_o,
    output logic               dn_w_valid_o,
    output w_req_t             dn_w_o,
    input  logic               dn_w_ready_i,
    input  logic               dn_b_valid_i,
    input  b_rsp_t             dn_b_i,
    output logic               dn_b_ready_o,
    output logic               up_b_valid_o,
    output b_rsp_t             up_b_o,
    input  logic               up_b_ready_i,
    output logic [ADDR_W-1:0]  check_addr_o,
    input  logic [N_SLOTS-1:0] hit_i,
    output resv_clr_t          resv_clr_o
);

    typedef enum logic [2:0] {
        AW_IDLE,
        W_FORWARD,
        W_DROP,
        B_FORWARD,
        B_INJECT
    } w_state_e;

    w_state_e          w_state_d, w_state_q;
    logic              excl_d, excl_q;
    logic              in_range_q;
    logic [ADDR_W-1:0] addr_q;
    logic [ID_W-1:0]   id_q;
    logic              aw_in_range;
    logic              aw_excl;
    logic              aw_hit;

    assign aw_in_range  = (up_aw_i.addr >= ADDR_BEGIN) && (up_aw_i.addr <= ADDR_END);
    assign aw_excl      = up_aw_i.lock && aw_in_range;
    assign check_addr_o = up_aw_i.addr;
    assign aw_hit       = hit_i[up_aw_i.id];

    always_comb begin
        dn_aw_o      = up_aw_i;
        dn_aw_o.lock = 1'b0;
    end

    assign dn_w_o = up_w_i;

    always_comb begin
        dn_aw_valid_o = 1'b0;
        up_aw_ready_o = 1'b0;
        dn_w_valid_o  = 1'b0;
        up_w_ready_o  = 1'b0;
        dn_b_ready_o  = 1'b0;
        up_b_valid_o  = 1'b0;
        up_b_o        = dn_b_i;
        resv_clr_o    = '{valid: 1'b0, addr: addr_q};
        excl_d        = excl_q;
        w_state_d     = w_state_q;

        case (w_state_q)
            AW_IDLE: begin
                if (aw_excl && !aw_hit) begin
                    // Reservation lost, accept here and drop the data beat
                    up_aw_ready_o = 1'b1;
                    if (up_aw_valid_i) begin
                        w_state_d = W_DROP;
                    end
                end else begin
                    dn_aw_valid_o = up_aw_valid_i;
                    up_aw_ready_o = dn_aw_ready_i;
                    if (up_aw_valid_i && dn_aw_ready_i) begin
                        excl_d    = aw_excl;
                        w_state_d = W_FORWARD;
                    end
                end
            end
            W_FORWARD: begin
                dn_w_valid_o = up_w_valid_i;
                up_w_ready_o = dn_w_ready_i;
                if (up_w_valid_i && dn_w_ready_i) begin
                    // Any write reaching memory kills reservations on its address
                    resv_clr_o.valid = in_range_q;
                    w_state_d        = B_FORWARD;
                end
            end
            W_DROP: begin
                up_w_ready_o = 1'b1;
                if (up_w_valid_i) begin
                    w_state_d = B_INJECT;
                end
            end
            B_FORWARD: begin
                dn_b_ready_o = up_b_ready_i;
                up_b_valid_o = dn_b_valid_i;
                if (!dn_b_i.resp[1]) begin
                    up_b_o.resp = excl_q ? RESP_EXOKAY : RESP_OKAY;
                end
                if (dn_b_valid_i && up_b_ready_i) begin
                    excl_d    = 1'b0;
                    w_state_d = AW_IDLE;
                end
            end
            B_INJECT: begin
                up_b_valid_o = 1'b1;
                up_b_o.id    = id_q;
                up_b_o.resp  = RESP_OKAY;
                if (up_b_ready_i) begin
                    w_state_d = AW_IDLE;
                end
            end
            default: w_state_d = AW_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            w_state_q  <= AW_IDLE;
            excl_q     <= 1'b0;
            in_range_q <= 1'b0;
        end else begin
            w_state_q <= w_state_d;
            excl_q    <= excl_d;
            if (up_aw_valid_i && up_aw_ready_o) begin
                in_range_q <= aw_in_range;
            end
        end
    end

    // Address and ID of the accepted AW
    always_ff @(posedge clk_i) begin
        if (up_aw_valid_i && up_aw_ready_o) begin
            addr_q <= up_aw_i.addr;
            id_q   <= up_aw_i.id;
        end
    end

endmodule

// ==== src.f ====
logic/lrsc_pkg.sv
logic/lrsc_resv_slot.sv
logic/lrsc_read_ctrl.sv
logic/lrsc_write_ctrl.sv
logic/lrsc_adapter.sv
verification/lrsc_tb.sv

// ==== verification/lrsc_tb.sv ====
// ==========================================================
// Testbench for the exclusive-access adapter with random traffic
// against a memory model and a reservation reference model
// ==========================================================
`timescale 1ns/100ps

module lrsc_tb
    import lrsc_pkg::*;
();

    localparam int          TIMEOUT  = 200;
    localparam int          N_OPS    = 400;
    localparam logic [15:0] WIN_LO   = 16'h1000;
    localparam logic [15:0] WIN_HI   = 16'h10FF;

    logic clk_i, rst_ni;
    logic up_ar_valid_i, up_ar_ready_o, up_r_valid_o, up_r_ready_i;
    logic up_aw_valid_i, up_aw_ready_o, up_w_valid_i, up_w_ready_o;
    logic up_b_valid_o, up_b_ready_i;
    logic dn_ar_valid_o, dn_ar_ready_i, dn_r_valid_i, dn_r_ready_o;
    logic dn_aw_valid_o, dn_aw_ready_i, dn_w_valid_o, dn_w_ready_i;
    logic dn_b_valid_i, dn_b_ready_o;
    ar_req_t up_ar_i, dn_ar_o;
    aw_req_t up_aw_i, dn_aw_o;
    w_req_t  up_w_i, dn_w_o;
    r_rsp_t  up_r_o, dn_r_i;
    b_rsp_t  up_b_o, dn_b_i;

    logic [15:0]       lfsr;
    logic [DATA_W-1:0] mem_q  [8];
    logic [DATA_W-1:0] shadow [8];
    logic              resv_ok   [N_SLOTS];
    logic [ADDR_W-1:0] resv_addr [N_SLOTS];
    logic [ID_W-1:0]   last_id;
    logic [ADDR_W-1:0] last_addr;
    int                n_excl_ok, n_drop;

    lrsc_adapter #(
        .ADDR_BEGIN (WIN_LO),
        .ADDR_END   (WIN_HI)
    ) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    // Test addresses with a few inside the window and a few just outside
    function automatic logic [ADDR_W-1:0] addr_of(input int idx);
        case (idx)
            0: return 16'h1000;
            1: return 16'h1008;
            2: return 16'h1010;
            3: return 16'h1004;
            4: return 16'h10FC;
            5: return 16'h0FFC;
            6: return 16'h1100;
            default: return 16'h2000;
        endcase
    endfunction

    function automatic int addr_index(input logic [ADDR_W-1:0] a);
        for (int i = 0; i < 8; i++) begin
            if (addr_of(i) == a) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic in_window(input logic [ADDR_W-1:0] a);
        return (a >= WIN_LO) && (a <= WIN_HI);
    endfunction

    task automatic fail_now(input string msg);
        $display("ERROR: %s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped on mismatch");
        end
    endtask

    task automatic idle_inputs();
        up_ar_valid_i = 1'b0;
        up_ar_i       = '0;
        up_r_ready_i  = 1'b0;
        up_aw_valid_i = 1'b0;
        up_aw_i       = '0;
        up_w_valid_i  = 1'b0;
        up_w_i        = '0;
        up_b_ready_i  = 1'b0;
        dn_ar_ready_i = 1'b0;
        dn_r_valid_i  = 1'b0;
        dn_r_i        = '0;
        dn_aw_ready_i = 1'b0;
        dn_w_ready_i  = 1'b0;
        dn_b_valid_i  = 1'b0;
        dn_b_i        = '0;
    endtask

    task automatic do_read(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input logic lock);
        logic              excl, ar_go, ar_done, r_pend, r_go, r_done;
        resp_e             exp_resp;
        logic [DATA_W-1:0] exp_data;
        logic [ADDR_W-1:0] m_addr;
        logic [ID_W-1:0]   m_id;
        int                m_idx, timer;
        excl     = lock && in_window(addr);
        exp_resp = addr[2] ? RESP_SLVERR : (excl ? RESP_EXOKAY : RESP_OKAY);
        exp_data = shadow[addr_index(addr)];
        if (excl) begin
            resv_ok[id]   = 1'b1;
            resv_addr[id] = addr;
            last_id       = id;
            last_addr     = addr;
        end
        {ar_go, ar_done, r_pend, r_go, r_done} = '0;
        m_addr = '0;
        m_id   = '0;
        m_idx  = 0;
        timer  = 0;
        while (!r_done) begin
            @(negedge clk_i);
            ar_go         = ar_go | rand_bit();
            up_ar_valid_i = ar_go && !ar_done;
            up_ar_i       = '{id: id, addr: addr, lock: lock};
            dn_ar_ready_i = rand_bit();
            if (r_pend) begin
                r_go = r_go | rand_bit();
            end
            dn_r_valid_i  = r_pend && r_go;
            dn_r_i        = '{id: m_id, data: mem_q[m_idx],
                              resp: (m_addr[2] ? RESP_SLVERR : RESP_OKAY)};
            up_r_ready_i  = rand_bit();
            #10;
            check_val("dn_ar_handshake", dn_ar_valid_o && dn_ar_ready_i,
                      up_ar_valid_i && up_ar_ready_o);
            if (dn_ar_valid_o && dn_ar_ready_i) begin
                check_val("dn_ar_o.lock", dn_ar_o.lock, 1'b0);
                check_val("dn_ar_o.addr", dn_ar_o.addr, addr);
                check_val("dn_ar_o.id", dn_ar_o.id, id);
                m_addr  = dn_ar_o.addr;
                m_id    = dn_ar_o.id;
                m_idx   = addr_index(m_addr);
                r_pend  = 1'b1;
                ar_done = 1'b1;
            end
            if (up_r_valid_o && up_r_ready_i) begin
                check_val("dn_r_ready_o", dn_r_ready_o, 1'b1);
                check_val("up_r_o.id", up_r_o.id, id);
                check_val("up_r_o.data", up_r_o.data, exp_data);
                check_val("up_r_o.resp", up_r_o.resp, exp_resp);
                r_done = 1'b1;
            end
            timer++;
            if (timer == TIMEOUT) begin
                fail_now("read transaction did not complete in time");
            end
        end
    endtask

    task automatic do_write(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input logic lock, input logic [DATA_W-1:0] data);
        logic              in_win, excl, fwd;
        logic              aw_go, aw_done, w_go, w_done, w_prev, b_pend, b_go, b_done;
        resp_e             exp_resp;
        logic [ADDR_W-1:0] m_addr;
        logic [ID_W-1:0]   m_id;
        int                n_aw, n_w, timer;
        in_win = in_window(addr);
        excl   = lock && in_win;
        fwd    = !excl || (resv_ok[id] && (resv_addr[id] == addr));
        if (!fwd) begin
            exp_resp = RESP_OKAY;
            n_drop++;
        end else begin
            exp_resp = addr[2] ? RESP_SLVERR : (excl ? RESP_EXOKAY : RESP_OKAY);
            if (!addr[2]) begin
                shadow[addr_index(addr)] = data;
            end
            // A write reaching memory ends every reservation on its address
            for (int i = 0; i < N_SLOTS; i++) begin
                if (in_win && (resv_addr[i] == addr)) begin
                    resv_ok[i] = 1'b0;
                end
            end
        end
        if (excl && fwd) begin
            n_excl_ok++;
        end
        {aw_go, aw_done, w_go, w_done, b_pend, b_go, b_done} = '0;
        m_addr = '0;
        m_id   = '0;
        n_aw   = 0;
        n_w    = 0;
        timer  = 0;
        while (!b_done) begin
            @(negedge clk_i);
            aw_go         = aw_go | rand_bit();
            up_aw_valid_i = aw_go && !aw_done;
            up_aw_i       = '{id: id, addr: addr, lock: lock};
            w_go          = w_go | rand_bit();
            up_w_valid_i  = w_go && !w_done;
            up_w_i        = '{data: data, strb: '1};
            dn_aw_ready_i = rand_bit();
            dn_w_ready_i  = rand_bit();
            if (b_pend) begin
                b_go = b_go | rand_bit();
            end
            dn_b_valid_i  = b_pend && b_go;
            dn_b_i        = '{id: m_id, resp: (m_addr[2] ? RESP_SLVERR : RESP_OKAY)};
            up_b_ready_i  = rand_bit();
            #10;
            w_prev = w_done;
            check_val("dn_aw_handshake", dn_aw_valid_o && dn_aw_ready_i,
                      up_aw_valid_i && up_aw_ready_o && fwd);
            check_val("dn_w_handshake", dn_w_valid_o && dn_w_ready_i,
                      up_w_valid_i && up_w_ready_o && fwd);
            if (up_aw_valid_i && up_aw_ready_o) begin
                aw_done = 1'b1;
            end
            if (up_w_valid_i && up_w_ready_o) begin
                w_done = 1'b1;
            end
            if (dn_aw_valid_o && dn_aw_ready_i) begin
                check_val("dn_aw_o.lock", dn_aw_o.lock, 1'b0);
                check_val("dn_aw_o.addr", dn_aw_o.addr, addr);
                check_val("dn_aw_o.id", dn_aw_o.id, id);
                m_addr = dn_aw_o.addr;
                m_id   = dn_aw_o.id;
                n_aw++;
            end
            if (dn_w_valid_o && dn_w_ready_i) begin
                check_val("dn_w_o.data", dn_w_o.data, data);
                check_val("dn_w_o.strb", dn_w_o.strb, {STRB_W{1'b1}});
                // Error addresses leave the memory untouched
                if (!m_addr[2]) begin
                    mem_q[addr_index(m_addr)] = dn_w_o.data;
                end
                b_pend = 1'b1;
                n_w++;
            end
            if (up_b_valid_o && up_b_ready_i) begin
                check_val("w_accepted_before_b", w_prev, 1'b1);
                check_val("dn_b_ready_o", dn_b_ready_o, fwd);
                check_val("up_b_o.id", up_b_o.id, id);
                check_val("up_b_o.resp", up_b_o.resp, exp_resp);
                b_done = 1'b1;
            end
            timer++;
            if (timer == TIMEOUT) begin
                fail_now("write transaction did not complete in time");
            end
        end
        check_val("dn_aw_count", n_aw, fwd);
        check_val("dn_w_count", n_w, fwd);
    endtask

    initial begin
        logic [31:0]       r;
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic              lock;
        rst_ni    = 1'b0;
        lfsr      = 16'd43340;
        last_id   = '0;
        last_addr = addr_of(0);
        n_excl_ok = 0;
        n_drop    = 0;
        idle_inputs();
        for (int i = 0; i < 8; i++) begin
            mem_q[i]  = {addr_of(i), addr_of(i) ^ 16'h5A3C};
            shadow[i] = mem_q[i];
        end
        for (int i = 0; i < N_SLOTS; i++) begin
            resv_ok[i]   = 1'b0;
            resv_addr[i] = '0;
        end
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;
        #10;
        check_val("up_r_valid_o", up_r_valid_o, 1'b0);
        check_val("up_b_valid_o", up_b_valid_o, 1'b0);
        check_val("up_w_ready_o", up_w_ready_o, 1'b0);
        check_val("dn_w_valid_o", dn_w_valid_o, 1'b0);
        check_val("dn_r_ready_o", dn_r_ready_o, 1'b0);
        for (int n = 0; n < N_OPS; n++) begin
            r    = rand_bits(8);
            id   = r[2:1];
            lock = r[3];
            addr = addr_of(int'(r[6:4]));
            data = rand_bits(32);
            if (r[0]) begin
                do_read(id, addr, lock);
            end else begin
                // Often retry the last exclusive read as a store-conditional
                if (r[7]) begin
                    id   = last_id;
                    addr = last_addr;
                    lock = 1'b1;
                end
                do_write(id, addr, lock, data);
            end
        end
        if ((n_excl_ok == 0) || (n_drop == 0)) begin
            fail_now("random traffic never produced both a kept and a dropped exclusive write");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
